/* filelist.f */
src/lab_pkg.sv
src/sync_and_debounce.sv
src/serial_shifter.sv
src/seq_detect_moore.sv
src/seq_detect_mealy.sv
src/event_counters.sv
src/seven_segment_display.sv
src/board_top.sv
sim/board_checker.sv
sim/tb_board_top.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the board_top testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"
rm -rf obj_dir

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_board_top -f filelist.f -o tb_board_top

./obj_dir/tb_board_top | tee sim.log

if grep -q "RESULT: FAIL" sim.log; then
    echo "simulation reported failure"
    exit 1
fi
echo "simulation finished without failure"

/* sim/board_checker.sv */
module board_checker (
    input  logic                      clk,
    input  logic                      i_rst_n,
    input  logic [lab_pkg::KEY_W-1:0] i_key,
    input  logic [lab_pkg::SW_W-1:0]  i_sw,
    input  logic [lab_pkg::LED_W-1:0] i_led,
    input  logic [7:0]                i_hex0,
    input  logic [7:0]                i_hex1,
    input  logic [7:0]                i_hex2,
    input  logic [7:0]                i_hex3,
    input  logic [7:0]                i_hex4,
    input  logic [7:0]                i_hex5,
    output int                        o_error_count,
    output int                        o_check_count,
    output int                        o_strobe_count
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int HOLD_SETTLE = 14;  // a pressed hold key has stopped the strobe by then
    localparam int SW_SETTLE   = 12;  // synchronizer plus debounce plus margin

    typedef struct packed {
        logic [2:0] window;    // last three consumed bits
        logic       last_hit;  // previous bit closed the pattern
        logic [7:0] mealy;
        logic [7:0] moore;
    } model_t;

    logic [7:0]                hex [lab_pkg::DIGITS];
    logic [3:0]                nib [lab_pkg::DIGITS];
    logic [4:0]                decoded;
    logic [15:0]               data_hist = '0;  // data key level per cycle with newest in bit 0
    logic [lab_pkg::LED_W-1:0] prev_led = '0;
    logic [lab_pkg::SW_W-1:0]  prev_sw = '0;
    logic [7:0]                prev_byte = '0;
    logic [7:0]                strobe_byte = '0;
    logic                      exp_bit;
    logic                      dp_exp;
    logic                      after_reset = 1'b0;
    model_t                    model = '0;
    int                        exp_strobes = 0;
    int                        errors = 0;
    int                        checks = 0;
    int                        held_cycles = 0;
    int                        sw_stable = 0;

    assign hex[0] = i_hex0;
    assign hex[1] = i_hex1;
    assign hex[2] = i_hex2;
    assign hex[3] = i_hex3;
    assign hex[4] = i_hex4;
    assign hex[5] = i_hex5;

    // {valid, nibble} for a segment pattern
    function automatic logic [4:0] decode_digit(input logic [6:0] seg);
        logic [4:0] result;
        result = 5'h00;
        for (int n = 0; n < 16; n++) begin
            if (lab_pkg::SEG_TABLE[n] == seg) result = {1'b1, 4'(n)};
        end
        return result;
    endfunction

    // expected detector counts after one more consumed bit
    function automatic model_t model_step(input model_t cur, input logic consumed);
        model_t nxt;
        nxt = cur;
        if (cur.last_hit) nxt.moore = cur.moore + 8'd1;  // moore lags by one bit
        nxt.window   = {cur.window[1:0], consumed};
        nxt.last_hit = (nxt.window == 3'b101);
        if (nxt.last_hit) nxt.mealy = cur.mealy + 8'd1;
        return nxt;
    endfunction

    task automatic compare_value(input string what, input int got, input int expected);
        checks++;
        if (got != expected) begin
            errors++;
            $display("ERROR at %0t ns: %s is %0d, expected %0d", $time, what, got, expected);
        end
    endtask

    always @(posedge clk) begin
        data_hist = {data_hist[14:0], ~i_key[1]};
        sw_stable = (i_sw == prev_sw) ? sw_stable + 1 : 0;
        prev_sw   = i_sw;
        if (!i_rst_n) begin
            model       = '0;
            exp_strobes = 0;
            strobe_byte = 8'h00;
            after_reset = 1'b1;
        end else begin
            for (int d = 0; d < lab_pkg::DIGITS; d++) begin
                decoded = decode_digit(hex[d][6:0]);
                nib[d]  = decoded[3:0];
                if (!decoded[4]) begin
                    errors++;
                    $display("ERROR at %0t ns: digit %0d shows %h, not a hex character",
                             $time, d, hex[d][6:0]);
                end
            end
            strobe_byte = {nib[5], nib[4]};
            if (after_reset) begin
                compare_value("led after reset", int'(i_led), 0);
                compare_value("strobe byte after reset", int'(strobe_byte), 0);
            end else if (strobe_byte != prev_byte) begin
                // the shift one edge ago took the level seen 10 edges before it
                exp_bit = data_hist[11];
                model = model_step(model, prev_led[0]);
                exp_strobes++;
                compare_value("led after shift", int'(i_led),
                              int'({exp_bit, prev_led[lab_pkg::LED_W-1:1]}));
                if (held_cycles >= HOLD_SETTLE) begin
                    errors++;
                    $display("ERROR at %0t ns: strobe count moved while hold key was pressed",
                             $time);
                end
            end else begin
                compare_value("led between strobes", int'(i_led), int'(prev_led));
            end
            compare_value("strobe byte", int'(strobe_byte), exp_strobes % 256);
            compare_value("moore count", int'({nib[3], nib[2]}), int'(model.moore));
            compare_value("mealy count", int'({nib[1], nib[0]}), int'(model.mealy));
            if (sw_stable >= SW_SETTLE) begin
                for (int d = 0; d < lab_pkg::SW_W; d++) begin
                    dp_exp = ~i_sw[d];  // decimal points are active low
                    compare_value($sformatf("decimal point %0d", d), int'(hex[d][7]),
                                  int'(dp_exp));
                end
            end
            after_reset = 1'b0;
        end
        held_cycles = (i_key[0] == 1'b0) ? held_cycles + 1 : 0;
        prev_led    = i_led;
        prev_byte   = strobe_byte;
        o_error_count  <= errors;
        o_check_count  <= checks;
        o_strobe_count <= exp_strobes;
    end

endmodule

/* sim/tb_board_top.sv */
module tb_board_top;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int DEPTH          = 3;
    localparam int STROBE_W       = 4;
    localparam int STROBE_TARGET  = 300;
    localparam int MIN_HOLD       = 16;   // short enough for a lone bit between strobes
    localparam int HOLD_SPAN      = 48;
    localparam int HOLD_SETTLE    = 14;
    localparam int HOLD_CYCLES    = 200;
    localparam int RESUME_TIMEOUT = 100;
    localparam int DP_TIMEOUT     = 40;

    logic                      clk;
    logic                      rst_n;
    logic [lab_pkg::KEY_W-1:0] key;  // active low like the board keys
    logic [lab_pkg::SW_W-1:0]  sw;
    logic [lab_pkg::LED_W-1:0] led;
    logic [7:0]                hex0;
    logic [7:0]                hex1;
    logic [7:0]                hex2;
    logic [7:0]                hex3;
    logic [7:0]                hex4;
    logic [7:0]                hex5;
    int                        checker_errors;
    int                        checks;
    int                        strobes;
    int                        tb_errors;
    logic [31:0]               lcg_state;

    board_top #(.DEBOUNCE_DEPTH(DEPTH), .STROBE_WIDTH(STROBE_W)) board_top_i (
        .clk(clk), .i_rst_n(rst_n), .i_key(key), .i_sw(sw), .o_led(led),
        .o_hex0(hex0), .o_hex1(hex1), .o_hex2(hex2),
        .o_hex3(hex3), .o_hex4(hex4), .o_hex5(hex5)
    );

    board_checker board_checker_i (
        .clk(clk), .i_rst_n(rst_n), .i_key(key), .i_sw(sw), .i_led(led),
        .i_hex0(hex0), .i_hex1(hex1), .i_hex2(hex2),
        .i_hex3(hex3), .i_hex4(hex4), .i_hex5(hex5),
        .o_error_count(checker_errors), .o_check_count(checks), .o_strobe_count(strobes)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // random data key levels until the checker has seen enough strobes
    task automatic stream_until(input int target);
        int   waited;
        int   limit;
        int   hold_len;
        logic level;
        waited = 0;
        limit  = (target - strobes + 4) * 64;
        while (strobes < target && waited < limit) begin
            lcg_state = lcg_next(lcg_state);
            level     = lcg_state[16];
            hold_len  = MIN_HOLD + int'(lcg_state[30:20]) % HOLD_SPAN;
            key[1]   <= ~level;
            repeat (hold_len) @(posedge clk);
            waited += hold_len;
        end
        if (strobes < target) begin
            tb_errors++;
            $display("timeout: only %0d of %0d strobes arrived", strobes, target);
        end
    endtask

    task automatic hold_and_release();
        int waited;
        int start;
        key[0] <= 1'b0;
        repeat (HOLD_SETTLE + HOLD_CYCLES) @(posedge clk);
        start  = strobes;
        key[0] <= 1'b1;
        waited = 0;
        while (strobes == start && waited < RESUME_TIMEOUT) begin
            @(posedge clk);
            waited++;
        end
        if (strobes == start) begin
            tb_errors++;
            $display("timeout: strobe did not resume after the hold key was released");
        end
    endtask

    task automatic drive_switches(input int rounds);
        int                       waited;
        logic [lab_pkg::SW_W-1:0] sw_val;
        logic [lab_pkg::SW_W-1:0] dp_now;
        repeat (rounds) begin
            lcg_state = lcg_next(lcg_state);
            sw_val    = lcg_state[21:16];
            sw       <= sw_val;
            waited    = 0;
            dp_now    = {hex5[7], hex4[7], hex3[7], hex2[7], hex1[7], hex0[7]};
            while (dp_now != ~sw_val && waited < DP_TIMEOUT) begin
                @(posedge clk);
                waited++;
                dp_now = {hex5[7], hex4[7], hex3[7], hex2[7], hex1[7], hex0[7]};
            end
            if (dp_now != ~sw_val) begin
                tb_errors++;
                $display("timeout: decimal points never followed switch value %b", sw_val);
            end
            repeat (8) @(posedge clk);  // checker compares the settled points
        end
    endtask

    initial begin
        lcg_state = 32'd10;
        tb_errors = 0;
        rst_n    <= 1'b0;
        key      <= 2'b11;
        sw       <= '0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        stream_until(STROBE_TARGET / 2);
        hold_and_release();
        stream_until(STROBE_TARGET);
        drive_switches(6);
        repeat (4) @(posedge clk);
        $display("checks: %0d, checker errors: %0d, testbench errors: %0d",
                 checks, checker_errors, tb_errors);
        if (checker_errors == 0 && tb_errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* src/board_top.sv */
module board_top #(
    parameter int DEBOUNCE_DEPTH = lab_pkg::DEBOUNCE_DEPTH_DEFAULT,
    parameter int STROBE_WIDTH   = lab_pkg::STROBE_WIDTH_DEFAULT
) (
    input  logic                      clk,
    input  logic                      i_rst_n,
    input  logic [lab_pkg::KEY_W-1:0] i_key,
    input  logic [lab_pkg::SW_W-1:0]  i_sw,
    output logic [lab_pkg::LED_W-1:0] o_led,
    output logic [7:0]                o_hex0,
    output logic [7:0]                o_hex1,
    output logic [7:0]                o_hex2,
    output logic [7:0]                o_hex3,
    output logic [7:0]                o_hex4,
    output logic [7:0]                o_hex5
);

    logic [lab_pkg::KEY_W-1:0]        key_db;  // 1 means pressed
    logic [lab_pkg::SW_W-1:0]         sw_db;
    logic                             shift_strobe;
    logic                             serial_bit;
    logic                             moore_hit;
    logic                             mealy_hit;
    logic [lab_pkg::STROBE_CNT_W-1:0] strobe_cnt;
    logic [lab_pkg::HIT_CNT_W-1:0]    moore_cnt;
    logic [lab_pkg::HIT_CNT_W-1:0]    mealy_cnt;
    logic [4*lab_pkg::DIGITS-1:0]     display_value;

    sync_and_debounce #(.W(lab_pkg::KEY_W), .DEPTH(DEBOUNCE_DEPTH)) key_debounce_i (
        .clk(clk), .i_rst_n(i_rst_n), .i_in(~i_key), .o_out(key_db)  // keys are active low
    );

    sync_and_debounce #(.W(lab_pkg::SW_W), .DEPTH(DEBOUNCE_DEPTH)) sw_debounce_i (
        .clk(clk), .i_rst_n(i_rst_n), .i_in(i_sw), .o_out(sw_db)
    );

    serial_shifter #(.STROBE_W(STROBE_WIDTH)) serial_shifter_i (
        .clk(clk), .i_rst_n(i_rst_n),
        .i_hold(key_db[0]), .i_data(key_db[1]),
        .o_shift_strobe(shift_strobe), .o_serial_bit(serial_bit), .o_led(o_led)
    );

    seq_detect_moore seq_detect_moore_i (
        .clk(clk), .i_rst_n(i_rst_n), .i_en(shift_strobe), .i_bit(serial_bit), .o_hit(moore_hit)
    );

    seq_detect_mealy seq_detect_mealy_i (
        .clk(clk), .i_rst_n(i_rst_n), .i_en(shift_strobe), .i_bit(serial_bit), .o_hit(mealy_hit)
    );

    event_counters event_counters_i (
        .clk(clk), .i_rst_n(i_rst_n),
        .i_strobe(shift_strobe), .i_moore_hit(moore_hit), .i_mealy_hit(mealy_hit),
        .o_strobe_cnt(strobe_cnt), .o_moore_cnt(moore_cnt), .o_mealy_cnt(mealy_cnt)
    );

    // only the low strobe byte fits on the six digits
    assign display_value = {strobe_cnt[7:0], moore_cnt, mealy_cnt};

    seven_segment_display seven_segment_display_i (
        .i_value(display_value), .i_dp_n(~sw_db),
        .o_hex0(o_hex0), .o_hex1(o_hex1), .o_hex2(o_hex2),
        .o_hex3(o_hex3), .o_hex4(o_hex4), .o_hex5(o_hex5)
    );

endmodule

/* src/event_counters.sv */
module event_counters (
    input  logic                             clk,
    input  logic                             i_rst_n,
    input  logic                             i_strobe,
    input  logic                             i_moore_hit,
    input  logic                             i_mealy_hit,
    output logic [lab_pkg::STROBE_CNT_W-1:0] o_strobe_cnt,
    output logic [lab_pkg::HIT_CNT_W-1:0]    o_moore_cnt,
    output logic [lab_pkg::HIT_CNT_W-1:0]    o_mealy_cnt
);

    logic moore_inc;
    logic mealy_inc;

    // a hit counts only on the edge that consumes a bit
    assign moore_inc = i_strobe & i_moore_hit;
    assign mealy_inc = i_strobe & i_mealy_hit;

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_strobe_cnt <= '0;
            o_moore_cnt  <= '0;
            o_mealy_cnt  <= '0;
        end else begin
            if (i_strobe) begin
                o_strobe_cnt <= o_strobe_cnt + 1'b1;  // wraps at 2^16
            end
            if (moore_inc) begin
                o_moore_cnt <= o_moore_cnt + 1'b1;
            end
            if (mealy_inc) begin
                o_mealy_cnt <= o_mealy_cnt + 1'b1;
            end
        end
    end

endmodule

/* src/lab_pkg.sv */
package lab_pkg;

    localparam int LED_W        = 10;  // shift register and led width
    localparam int SW_W         = 6;   // switches in use
    localparam int KEY_W        = 2;
    localparam int DIGITS       = 6;   // seven-segment digits on the board
    localparam int STROBE_CNT_W = 16;
    localparam int HIT_CNT_W    = 8;

    // board values, a simulation passes much smaller ones to board_top
    localparam int DEBOUNCE_DEPTH_DEFAULT = 8;
    localparam int STROBE_WIDTH_DEFAULT   = 23;

    localparam int PATTERN_LEN = 3;  // length of the 1-0-1 pattern

    typedef enum logic [1:0] {
        MOORE_IDLE,
        MOORE_GOT1,
        MOORE_GOT10,
        MOORE_HIT
    } moore_state_t;

    typedef enum logic [1:0] {
        MEALY_IDLE,
        MEALY_GOT1,
        MEALY_GOT10
    } mealy_state_t;

    // active-low segments, bit 0 is segment a
    localparam logic [6:0] SEG_TABLE [16] = '{
        7'h40, 7'h79, 7'h24, 7'h30,  // 0 1 2 3
        7'h19, 7'h12, 7'h02, 7'h78,  // 4 5 6 7
        7'h00, 7'h10, 7'h08, 7'h03,  // 8 9 A b
        7'h46, 7'h21, 7'h06, 7'h0e   // C d E F
    };

endpackage

/* src/seq_detect_mealy.sv */
module seq_detect_mealy (
    input  logic clk,
    input  logic i_rst_n,
    input  logic i_en,
    input  logic i_bit,
    output logic o_hit
);

    lab_pkg::mealy_state_t state;
    lab_pkg::mealy_state_t state_next;

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state <= lab_pkg::MEALY_IDLE;
        end else if (i_en) begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        unique case (state)
            lab_pkg::MEALY_IDLE:  state_next = i_bit ? lab_pkg::MEALY_GOT1 : lab_pkg::MEALY_IDLE;
            lab_pkg::MEALY_GOT1:  state_next = i_bit ? lab_pkg::MEALY_GOT1 : lab_pkg::MEALY_GOT10;
            lab_pkg::MEALY_GOT10: state_next = i_bit ? lab_pkg::MEALY_GOT1 : lab_pkg::MEALY_IDLE;
            default:              state_next = lab_pkg::MEALY_IDLE;  // unused encoding
        endcase
    end

    // hit in the same cycle as the bit that closes the pattern
    assign o_hit = i_en & (state == lab_pkg::MEALY_GOT10) & i_bit;

    a_hit_on_strobe: assert property (@(posedge clk) disable iff (!i_rst_n)
        o_hit |-> i_en ##1 (state == lab_pkg::MEALY_GOT1))
        else $error("mealy hit off the strobe or %0d-bit pattern not reopened",
                    lab_pkg::PATTERN_LEN);

endmodule

/* src/seq_detect_moore.sv */
module seq_detect_moore (
    input  logic clk,
    input  logic i_rst_n,
    input  logic i_en,
    input  logic i_bit,
    output logic o_hit
);

    lab_pkg::moore_state_t state;
    lab_pkg::moore_state_t state_next;

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state <= lab_pkg::MOORE_IDLE;
        end else if (i_en) begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        unique case (state)
            lab_pkg::MOORE_IDLE:  state_next = i_bit ? lab_pkg::MOORE_GOT1 : lab_pkg::MOORE_IDLE;
            lab_pkg::MOORE_GOT1:  state_next = i_bit ? lab_pkg::MOORE_GOT1 : lab_pkg::MOORE_GOT10;
            lab_pkg::MOORE_GOT10: state_next = i_bit ? lab_pkg::MOORE_HIT  : lab_pkg::MOORE_IDLE;
            // the closing 1 can open the next pattern
            lab_pkg::MOORE_HIT:   state_next = i_bit ? lab_pkg::MOORE_GOT1 : lab_pkg::MOORE_GOT10;
            default:              state_next = lab_pkg::MOORE_IDLE;
        endcase
    end

    assign o_hit = (state == lab_pkg::MOORE_HIT);  // one consumed bit late

    // HIT is entered only by a consumed 1 after 1-0, and left on the next bit
    a_hit_entry: assert property (@(posedge clk) disable iff (!i_rst_n)
        o_hit |-> $past((state == lab_pkg::MOORE_GOT10 && i_en && i_bit)
                        || (state == lab_pkg::MOORE_HIT && !i_en)))
        else $error("moore hit without a completed %0d-bit pattern",
                    lab_pkg::PATTERN_LEN);

endmodule

/* src/serial_shifter.sv */
module serial_shifter #(
    parameter int STROBE_W = 23
) (
    input  logic                     clk,
    input  logic                     i_rst_n,
    input  logic                     i_hold,
    input  logic                     i_data,
    output logic                     o_shift_strobe,
    output logic                     o_serial_bit,
    output logic [lab_pkg::LED_W-1:0] o_led
);

    logic [STROBE_W-1:0]       strobe_cnt;
    logic                      strobe_q;
    logic [lab_pkg::LED_W-1:0] shift_q;

    // free-running divider, frozen while the hold key is down
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            strobe_cnt <= '0;
            strobe_q   <= 1'b0;
        end else begin
            strobe_q <= ~i_hold & (&strobe_cnt);  // carry out of the divider
            if (!i_hold) begin
                strobe_cnt <= strobe_cnt + 1'b1;
            end
        end
    end

    // new bit enters at the top, bit 0 drops out to the detectors
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            shift_q <= '0;
        end else if (strobe_q) begin
            shift_q <= {i_data, shift_q[lab_pkg::LED_W-1:1]};
        end
    end

    assign o_shift_strobe = strobe_q;
    assign o_serial_bit   = shift_q[0];  // bit consumed on the strobe edge
    assign o_led          = shift_q;

    a_strobe_single: assert property (@(posedge clk) disable iff (!i_rst_n)
        o_shift_strobe |=> !o_shift_strobe)
        else $error("shift strobe lasted more than one cycle");

endmodule

/* src/seven_segment_display.sv */
module seven_segment_display (
    input  logic [4*lab_pkg::DIGITS-1:0] i_value,
    input  logic [lab_pkg::SW_W-1:0]     i_dp_n,
    output logic [7:0]                   o_hex0,
    output logic [7:0]                   o_hex1,
    output logic [7:0]                   o_hex2,
    output logic [7:0]                   o_hex3,
    output logic [7:0]                   o_hex4,
    output logic [7:0]                   o_hex5
);

    logic [7:0] digit_seg [lab_pkg::DIGITS];

    // one nibble per digit, decimal point on top
    for (genvar d = 0; d < lab_pkg::DIGITS; d++) begin : g_digit
        logic [3:0] nibble;

        assign nibble       = i_value[4*d +: 4];
        assign digit_seg[d] = {i_dp_n[d], lab_pkg::SEG_TABLE[nibble]};
    end

    assign o_hex0 = digit_seg[0];  // mealy count, low nibble
    assign o_hex1 = digit_seg[1];
    assign o_hex2 = digit_seg[2];  // moore count
    assign o_hex3 = digit_seg[3];
    assign o_hex4 = digit_seg[4];  // strobe count, low byte
    assign o_hex5 = digit_seg[5];

endmodule

/* src/sync_and_debounce.sv */
module sync_and_debounce #(
    parameter int W     = 1,
    parameter int DEPTH = 8
) (
    input  logic         clk,
    input  logic         i_rst_n,
    input  logic [W-1:0] i_in,
    output logic [W-1:0] o_out
);

    logic [W-1:0] sync_q1;
    logic [W-1:0] sync_q2;  // metastability-safe copy of i_in

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            sync_q1 <= '0;
            sync_q2 <= '0;
        end else begin
            sync_q1 <= i_in;
            sync_q2 <= sync_q1;
        end
    end

    // each bit counts how long the input has disagreed with the output
    for (genvar i = 0; i < W; i++) begin : g_bit
        logic [DEPTH-1:0] stable_cnt;
        logic             out_q;

        always_ff @(posedge clk or negedge i_rst_n) begin
            if (!i_rst_n) begin
                stable_cnt <= '0;
                out_q      <= 1'b0;
            end else if (sync_q2[i] == out_q) begin
                stable_cnt <= '0;  // bounced back, start over
            end else if (&stable_cnt) begin
                stable_cnt <= '0;
                out_q      <= sync_q2[i];  // held for 2^DEPTH cycles
            end else begin
                stable_cnt <= stable_cnt + 1'b1;
            end
        end

        assign o_out[i] = out_q;
    end

    a_out_follows_sync: assert property (@(posedge clk) disable iff (!i_rst_n)
        ((o_out ^ $past(o_out)) & (o_out ^ $past(sync_q2))) == '0)
        else $error("debounced output took a value the synchronizer did not hold");

endmodule
